// File: src/io_lite_pkg.sv
// io lite crossbar definitions

package io_lite_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // bus widths

   localparam int unsigned PADDR_WIDTH   = 32;
   localparam int unsigned IO_DAT_WIDTH  = 64;
   localparam int unsigned IO_STRB_WIDTH = IO_DAT_WIDTH / 8;  // one per byte lane

   ////////////////////////////////////////////////////////////////////////////
   // peripheral slots

   localparam int unsigned N_IO_DEVICE = 2;
   localparam int unsigned SLOT_W      = 1;

   localparam logic [SLOT_W-1:0] UART_SLOT = 1'b0;
   localparam logic [SLOT_W-1:0] SPI_SLOT  = 1'b1;

   // 64 KiB windows
   localparam logic [PADDR_WIDTH-1:0] UART_BASE = 32'h8000_0000;
   localparam logic [PADDR_WIDTH-1:0] SPI_BASE  = 32'h8001_0000;
   localparam logic [PADDR_WIDTH-1:0] DEV_MASK  = 32'h0000_ffff;  // offset bits

   ////////////////////////////////////////////////////////////////////////////
   // interrupts and responses

   localparam int unsigned IRQ_WIDTH = 64;

   localparam int unsigned RESP_W = 2;

   localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
   localparam logic [RESP_W-1:0] RESP_DECERR = 2'd3;  // unmapped address

endpackage

// File: src/io_req_decode.sv
// request capture and address decode
`timescale 1ns/100ps

module io_req_decode (
   input  logic                                       clk_i,
   input  logic                                       rst_n_i,
   // host request
   input  logic                                       req_valid_i,
   output logic                                       req_ready_o,
   input  logic                                       req_write_i,
   input  logic [io_lite_pkg::PADDR_WIDTH-1:0]        req_addr_i,
   input  logic [io_lite_pkg::IO_DAT_WIDTH-1:0]       req_wdata_i,
   input  logic [io_lite_pkg::IO_STRB_WIDTH-1:0]      req_wstrb_i,
   // from the router
   input  logic                                       route_done_i,
   // captured request
   output logic                                       cap_valid_o,
   output logic                                       cap_write_o,
   output logic [io_lite_pkg::PADDR_WIDTH-1:0]        cap_addr_o,
   output logic [io_lite_pkg::IO_DAT_WIDTH-1:0]       cap_wdata_o,
   output logic [io_lite_pkg::IO_STRB_WIDTH-1:0]      cap_wstrb_o,
   output logic [io_lite_pkg::SLOT_W-1:0]             cap_slot_o,
   output logic                                       cap_miss_o
);

   logic accept;
   logic hit_uart;
   logic hit_spi;

   assign req_ready_o = ~cap_valid_o;  // one request at a time
   assign accept      = req_valid_i & req_ready_o;

   // window match, offset bits ignored
   assign hit_uart = (req_addr_i & ~io_lite_pkg::DEV_MASK) ==
                     (io_lite_pkg::UART_BASE & ~io_lite_pkg::DEV_MASK);
   assign hit_spi  = (req_addr_i & ~io_lite_pkg::DEV_MASK) ==
                     (io_lite_pkg::SPI_BASE & ~io_lite_pkg::DEV_MASK);

   ////////////////////////////////////////////////////////////////////////////
   // occupancy

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cap_valid_o <= 1'b0;
      end else if (accept) begin
         cap_valid_o <= 1'b1;
      end else if (route_done_i) begin
         cap_valid_o <= 1'b0;  // response handed on
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // payload and decode result

   always_ff @(posedge clk_i) begin
      if (accept) begin
         cap_write_o <= req_write_i;
         cap_addr_o  <= req_addr_i;
         cap_wdata_o <= req_wdata_i;
         cap_wstrb_o <= req_wstrb_i;
         cap_slot_o  <= hit_spi ? io_lite_pkg::SPI_SLOT : io_lite_pkg::UART_SLOT;
         cap_miss_o  <= ~(hit_uart | hit_spi);
      end
   end

endmodule

// File: src/io_route.sv
// slot routing and response collection
`timescale 1ns/100ps

module io_route (
   input  logic                                                   clk_i,
   input  logic                                                   rst_n_i,
   // captured request
   input  logic                                                   cap_valid_i,
   input  logic                                                   cap_write_i,
   input  logic [io_lite_pkg::PADDR_WIDTH-1:0]                    cap_addr_i,
   input  logic [io_lite_pkg::IO_DAT_WIDTH-1:0]                   cap_wdata_i,
   input  logic [io_lite_pkg::IO_STRB_WIDTH-1:0]                  cap_wstrb_i,
   input  logic [io_lite_pkg::SLOT_W-1:0]                         cap_slot_i,
   input  logic                                                   cap_miss_i,
   output logic                                                   route_done_o,
   // device requests
   output logic [io_lite_pkg::N_IO_DEVICE-1:0]                    dev_req_valid_o,
   input  logic [io_lite_pkg::N_IO_DEVICE-1:0]                    dev_req_ready_i,
   output logic                                                   dev_req_write_o,
   output logic [io_lite_pkg::PADDR_WIDTH-1:0]                    dev_req_addr_o,
   output logic [io_lite_pkg::IO_DAT_WIDTH-1:0]                   dev_req_wdata_o,
   output logic [io_lite_pkg::IO_STRB_WIDTH-1:0]                  dev_req_wstrb_o,
   // device responses
   input  logic [io_lite_pkg::N_IO_DEVICE-1:0]                    dev_rsp_valid_i,
   output logic [io_lite_pkg::N_IO_DEVICE-1:0]                    dev_rsp_ready_o,
   input  logic [io_lite_pkg::N_IO_DEVICE-1:0]
                [io_lite_pkg::IO_DAT_WIDTH-1:0]                   dev_rsp_rdata_i,
   input  logic [io_lite_pkg::N_IO_DEVICE-1:0]
                [io_lite_pkg::RESP_W-1:0]                         dev_rsp_resp_i,
   // to the response buffer
   output logic                                                   buf_in_valid_o,
   input  logic                                                   buf_in_ready_i,
   output logic [io_lite_pkg::IO_DAT_WIDTH-1:0]                   buf_in_rdata_o,
   output logic [io_lite_pkg::RESP_W-1:0]                         buf_in_resp_o
);

   enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_WAIT} state_q, state_d;

   logic miss_now;

   // payload goes to every slot, only valid is steered
   assign dev_req_write_o = cap_write_i;
   assign dev_req_addr_o  = cap_addr_i;
   assign dev_req_wdata_o = cap_wdata_i;
   assign dev_req_wstrb_o = cap_wstrb_i;

   // a miss is answered straight from idle
   assign miss_now = (state_q == ST_IDLE) & cap_valid_i & cap_miss_i;

   ////////////////////////////////////////////////////////////////////////////
   // response path

   assign buf_in_valid_o = miss_now |
                           ((state_q == ST_WAIT) & dev_rsp_valid_i[cap_slot_i]);
   assign buf_in_rdata_o = cap_miss_i ? '0 : dev_rsp_rdata_i[cap_slot_i];
   assign buf_in_resp_o  = cap_miss_i ? io_lite_pkg::RESP_DECERR
                                      : dev_rsp_resp_i[cap_slot_i];
   assign route_done_o   = buf_in_valid_o & buf_in_ready_i;  // frees the decoder

   ////////////////////////////////////////////////////////////////////////////
   // FSM

   always_comb begin
      state_d         = state_q;
      dev_req_valid_o = '0;
      dev_rsp_ready_o = '0;
      case (state_q)
         ST_IDLE: begin
            if (cap_valid_i && !cap_miss_i) begin
               state_d = ST_ISSUE;
            end
         end
         ST_ISSUE: begin
            dev_req_valid_o[cap_slot_i] = 1'b1;
            if (dev_req_ready_i[cap_slot_i]) begin
               state_d = ST_WAIT;
            end
         end
         ST_WAIT: begin
            dev_rsp_ready_o[cap_slot_i] = buf_in_ready_i;  // stall while buffer full
            if (route_done_o) begin
               state_d = ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

endmodule

// File: src/io_resp_buffer.sv
// single entry response buffer
`timescale 1ns/100ps

module io_resp_buffer (
   input  logic                                       clk_i,
   input  logic                                       rst_n_i,
   // from the router
   input  logic                                       buf_in_valid_i,
   output logic                                       buf_in_ready_o,
   input  logic [io_lite_pkg::IO_DAT_WIDTH-1:0]       buf_in_rdata_i,
   input  logic [io_lite_pkg::RESP_W-1:0]             buf_in_resp_i,
   // host response
   output logic                                       rsp_valid_o,
   input  logic                                       rsp_ready_i,
   output logic [io_lite_pkg::IO_DAT_WIDTH-1:0]       rsp_rdata_o,
   output logic [io_lite_pkg::RESP_W-1:0]             rsp_resp_o
);

   logic full_q;
   logic fill;
   logic drain;

   assign buf_in_ready_o = ~full_q;
   assign rsp_valid_o    = full_q;

   assign fill  = buf_in_valid_i & buf_in_ready_o;
   assign drain = rsp_valid_o & rsp_ready_i;

   ////////////////////////////////////////////////////////////////////////////
   // full flag

   // fill and drain never meet, ready is low while full
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         full_q <= 1'b0;
      end else if (fill) begin
         full_q <= 1'b1;
      end else if (drain) begin
         full_q <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // entry

   always_ff @(posedge clk_i) begin
      if (fill) begin
         rsp_rdata_o <= buf_in_rdata_i;
         rsp_resp_o  <= buf_in_resp_i;  // held until host takes it
      end
   end

endmodule

// File: src/io_lite_xbar.sv
// io lite crossbar top
`timescale 1ns/100ps

module io_lite_xbar (
   input  logic                                                   clk_i,
   input  logic                                                   rst_n_i,
   // host request
   input  logic                                                   req_valid_i,
   output logic                                                   req_ready_o,
   input  logic                                                   req_write_i,
   input  logic [io_lite_pkg::PADDR_WIDTH-1:0]                    req_addr_i,
   input  logic [io_lite_pkg::IO_DAT_WIDTH-1:0]                   req_wdata_i,
   input  logic [io_lite_pkg::IO_STRB_WIDTH-1:0]                  req_wstrb_i,
   // host response
   output logic                                                   rsp_valid_o,
   input  logic                                                   rsp_ready_i,
   output logic [io_lite_pkg::IO_DAT_WIDTH-1:0]                   rsp_rdata_o,
   output logic [io_lite_pkg::RESP_W-1:0]                         rsp_resp_o,
   // device requests
   output logic [io_lite_pkg::N_IO_DEVICE-1:0]                    dev_req_valid_o,
   input  logic [io_lite_pkg::N_IO_DEVICE-1:0]                    dev_req_ready_i,
   output logic                                                   dev_req_write_o,
   output logic [io_lite_pkg::PADDR_WIDTH-1:0]                    dev_req_addr_o,
   output logic [io_lite_pkg::IO_DAT_WIDTH-1:0]                   dev_req_wdata_o,
   output logic [io_lite_pkg::IO_STRB_WIDTH-1:0]                  dev_req_wstrb_o,
   // device responses
   input  logic [io_lite_pkg::N_IO_DEVICE-1:0]                    dev_rsp_valid_i,
   output logic [io_lite_pkg::N_IO_DEVICE-1:0]                    dev_rsp_ready_o,
   input  logic [io_lite_pkg::N_IO_DEVICE-1:0]
                [io_lite_pkg::IO_DAT_WIDTH-1:0]                   dev_rsp_rdata_i,
   input  logic [io_lite_pkg::N_IO_DEVICE-1:0]
                [io_lite_pkg::RESP_W-1:0]                         dev_rsp_resp_i,
   // interrupts
   input  logic [io_lite_pkg::N_IO_DEVICE-1:0]                    dev_irq_i,
   output logic [io_lite_pkg::IRQ_WIDTH-1:0]                      irq_o
);

   logic                                      cap_valid;
   logic                                      cap_write;
   logic [io_lite_pkg::PADDR_WIDTH-1:0]       cap_addr;
   logic [io_lite_pkg::IO_DAT_WIDTH-1:0]      cap_wdata;
   logic [io_lite_pkg::IO_STRB_WIDTH-1:0]     cap_wstrb;
   logic [io_lite_pkg::SLOT_W-1:0]            cap_slot;
   logic                                      cap_miss;
   logic                                      route_done;

   logic                                      buf_in_valid;
   logic                                      buf_in_ready;
   logic [io_lite_pkg::IO_DAT_WIDTH-1:0]      buf_in_rdata;
   logic [io_lite_pkg::RESP_W-1:0]            buf_in_resp;

   ////////////////////////////////////////////////////////////////////////////
   // request, route, response

   io_req_decode io_req_decode_i (
      .clk_i        ( clk_i        ),
      .rst_n_i      ( rst_n_i      ),
      .req_valid_i  ( req_valid_i  ),
      .req_ready_o  ( req_ready_o  ),
      .req_write_i  ( req_write_i  ),
      .req_addr_i   ( req_addr_i   ),
      .req_wdata_i  ( req_wdata_i  ),
      .req_wstrb_i  ( req_wstrb_i  ),
      .route_done_i ( route_done   ),
      .cap_valid_o  ( cap_valid    ),
      .cap_write_o  ( cap_write    ),
      .cap_addr_o   ( cap_addr     ),
      .cap_wdata_o  ( cap_wdata    ),
      .cap_wstrb_o  ( cap_wstrb    ),
      .cap_slot_o   ( cap_slot     ),
      .cap_miss_o   ( cap_miss     )
   );

   io_route io_route_i (
      .clk_i           ( clk_i           ),
      .rst_n_i         ( rst_n_i         ),
      .cap_valid_i     ( cap_valid       ),
      .cap_write_i     ( cap_write       ),
      .cap_addr_i      ( cap_addr        ),
      .cap_wdata_i     ( cap_wdata       ),
      .cap_wstrb_i     ( cap_wstrb       ),
      .cap_slot_i      ( cap_slot        ),
      .cap_miss_i      ( cap_miss        ),
      .route_done_o    ( route_done      ),
      .dev_req_valid_o ( dev_req_valid_o ),
      .dev_req_ready_i ( dev_req_ready_i ),
      .dev_req_write_o ( dev_req_write_o ),
      .dev_req_addr_o  ( dev_req_addr_o  ),
      .dev_req_wdata_o ( dev_req_wdata_o ),
      .dev_req_wstrb_o ( dev_req_wstrb_o ),
      .dev_rsp_valid_i ( dev_rsp_valid_i ),
      .dev_rsp_ready_o ( dev_rsp_ready_o ),
      .dev_rsp_rdata_i ( dev_rsp_rdata_i ),
      .dev_rsp_resp_i  ( dev_rsp_resp_i  ),
      .buf_in_valid_o  ( buf_in_valid    ),
      .buf_in_ready_i  ( buf_in_ready    ),
      .buf_in_rdata_o  ( buf_in_rdata    ),
      .buf_in_resp_o   ( buf_in_resp     )
   );

   io_resp_buffer io_resp_buffer_i (
      .clk_i          ( clk_i        ),
      .rst_n_i        ( rst_n_i      ),
      .buf_in_valid_i ( buf_in_valid ),
      .buf_in_ready_o ( buf_in_ready ),
      .buf_in_rdata_i ( buf_in_rdata ),
      .buf_in_resp_i  ( buf_in_resp  ),
      .rsp_valid_o    ( rsp_valid_o  ),
      .rsp_ready_i    ( rsp_ready_i  ),
      .rsp_rdata_o    ( rsp_rdata_o  ),
      .rsp_resp_o     ( rsp_resp_o   )
   );

   ////////////////////////////////////////////////////////////////////////////
   // interrupt vector

   always_comb begin
      irq_o                         = '0;  // upper lines unused
      irq_o[io_lite_pkg::UART_SLOT] = dev_irq_i[io_lite_pkg::UART_SLOT];
      irq_o[io_lite_pkg::SPI_SLOT]  = dev_irq_i[io_lite_pkg::SPI_SLOT];
   end

endmodule

// File: bench/tb_periph_model.sv
// peripheral slot responder
`timescale 1ns/100ps

module tb_periph_model #(
   parameter int SLOT = 0
) (
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        req_valid_i,
   output logic        req_ready_o,
   input  logic        req_write_i,
   input  logic [31:0] req_addr_i,
   output logic        rsp_valid_o,
   input  logic        rsp_ready_i,
   output logic [63:0] rsp_rdata_o,
   output logic [1:0]  rsp_resp_o,
   input  logic [1:0]  acc_delay_i,
   input  logic [1:0]  rsp_delay_i
);

   initial begin
      req_ready_o = 1'b0;
      rsp_valid_o = 1'b0;
      rsp_rdata_o = '0;
      rsp_resp_o  = io_lite_pkg::RESP_OKAY;
   end

   always begin
      @(negedge clk_i);
      if (rst_n_i && req_valid_i) begin
         repeat (acc_delay_i) @(negedge clk_i);
         req_ready_o = 1'b1;
         rsp_rdata_o = req_write_i ? 64'h0
                                   : ({32'h0, req_addr_i} ^ 64'h5a5a_0000_0000_0000) + 64'(SLOT);
         @(negedge clk_i);  // request taken
         req_ready_o = 1'b0;
         repeat (rsp_delay_i) @(negedge clk_i);
         rsp_valid_o = 1'b1;
         while (!rsp_ready_i) @(negedge clk_i);
         @(negedge clk_i);
         rsp_valid_o = 1'b0;
      end
   end

endmodule

// File: bench/tb_io_lite_xbar.sv
// io lite crossbar testbench
`timescale 1ns/100ps

module tb_io_lite_xbar;

   localparam int N_DIRECTED  = 9;
   localparam int N_RANDOM    = 200;
   localparam int CYCLE_LIMIT = 60 * (N_DIRECTED + N_RANDOM) + 100;

   logic              clk_i;
   logic              rst_n_i;
   logic              req_valid_i;
   logic              req_ready_o;
   logic              req_write_i;
   logic [31:0]       req_addr_i;
   logic [63:0]       req_wdata_i;
   logic [7:0]        req_wstrb_i;
   logic              rsp_valid_o;
   logic              rsp_ready_i;
   logic [63:0]       rsp_rdata_o;
   logic [1:0]        rsp_resp_o;
   logic [1:0]        dev_req_valid_o;
   wire  [1:0]        dev_req_ready_i;
   logic              dev_req_write_o;
   logic [31:0]       dev_req_addr_o;
   logic [63:0]       dev_req_wdata_o;
   logic [7:0]        dev_req_wstrb_o;
   wire  [1:0]        dev_rsp_valid_i;
   logic [1:0]        dev_rsp_ready_o;
   wire  [1:0][63:0]  dev_rsp_rdata_i;
   wire  [1:0][1:0]   dev_rsp_resp_i;
   logic [1:0]        dev_irq_i;
   logic [63:0]       irq_o;

   logic [31:0] lfsr_state;
   logic [1:0]  acc_delay [2];
   logic [1:0]  rsp_delay [2];
   int          rsp_mode;  // 0 always ready, 1 random gaps, 2 held low
   string       cur_test;
   int          errors;
   int          checked;
   int          held_accepts;
   int          cycles;

   logic [65:0] ref_q [$];  // {resp, rdata} per accepted request
   logic [1:0]  last_sel;
   logic [31:0] last_addr;
   logic        last_write;
   logic [63:0] last_wdata;
   logic [7:0]  last_wstrb;

   logic        gen_write [N_RANDOM];
   logic [31:0] gen_addr  [N_RANDOM];
   logic [63:0] gen_wdata [N_RANDOM];
   logic [7:0]  gen_wstrb [N_RANDOM];

   io_lite_xbar io_lite_xbar_i (.*);

   for (genvar s = 0; s < 2; s++) begin : slot
      tb_periph_model #(.SLOT(s)) periph_i (
         .clk_i       ( clk_i              ),
         .rst_n_i     ( rst_n_i            ),
         .req_valid_i ( dev_req_valid_o[s] ),
         .req_ready_o ( dev_req_ready_i[s] ),
         .req_write_i ( dev_req_write_o    ),
         .req_addr_i  ( dev_req_addr_o     ),
         .rsp_valid_o ( dev_rsp_valid_i[s] ),
         .rsp_ready_i ( dev_rsp_ready_o[s] ),
         .rsp_rdata_o ( dev_rsp_rdata_i[s] ),
         .rsp_resp_o  ( dev_rsp_resp_i[s]  ),
         .acc_delay_i ( acc_delay[s]       ),
         .rsp_delay_i ( rsp_delay[s]       )
      );
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
   endfunction

   task automatic draw(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[62:0], lfsr_state[0]};
      end
   endtask

   // one-hot slot select, zero for unmapped
   function automatic logic [1:0] window_sel(input logic [31:0] a);
      logic [31:0] page;
      page = a & ~io_lite_pkg::DEV_MASK;
      if (page == (io_lite_pkg::UART_BASE & ~io_lite_pkg::DEV_MASK)) return 2'b01;
      if (page == (io_lite_pkg::SPI_BASE & ~io_lite_pkg::DEV_MASK)) return 2'b10;
      return 2'b00;
   endfunction

   function automatic logic [65:0] expected_rsp(input logic w, input logic [31:0] a);
      logic [1:0] sel;
      sel = window_sel(a);
      if (sel == 2'b00) return {io_lite_pkg::RESP_DECERR, 64'h0};
      if (w) return {io_lite_pkg::RESP_OKAY, 64'h0};
      return {io_lite_pkg::RESP_OKAY,
              ({32'h0, a} ^ 64'h5a5a_0000_0000_0000) + {63'h0, sel[1]}};
   endfunction

   task automatic show_mismatch(input string name, input logic [65:0] want,
                                input logic [65:0] got);
      errors++;
      $display("** Error [%s] expected %h, actual %h", name, want, got);
   endtask

   task automatic problem(input string msg);
      errors++;
      $display("%s at %0t", msg, $time);
   endtask

   task automatic send(input logic w, input logic [31:0] a, input logic [63:0] d,
                       input logic [7:0] strb);
      @(negedge clk_i);
      req_write_i = w;
      req_addr_i  = a;
      req_wdata_i = d;
      req_wstrb_i = strb;
      req_valid_i = 1'b1;
      while (!req_ready_o) @(negedge clk_i);
      @(negedge clk_i);  // taken on the edge between
      req_valid_i = 1'b0;
   endtask

   task automatic drain();
      while (ref_q.size() != 0) @(negedge clk_i);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // clock, random inputs, watchdog, monitor

   always #50 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      logic [63:0] r;
      if (rst_n_i) begin
         draw(8, r);
         acc_delay[0] = r[1:0];
         acc_delay[1] = r[3:2];
         rsp_delay[0] = r[5:4];
         rsp_delay[1] = r[7:6];
      end
   end

   always @(negedge clk_i) begin
      logic [63:0] r;
      draw(3, r);
      dev_irq_i   = r[1:0];
      rsp_ready_i = (rsp_mode == 0) || (rsp_mode == 1 && r[2]);
   end

   always @(posedge clk_i) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         problem("timeout with responses still outstanding");
         $display("checked %0d responses, %0d errors", checked, errors);
         $display("test failed");
         $finish;
      end
   end

   always @(posedge clk_i) begin
      logic [65:0] want;
      if (rst_n_i) begin
         if (rsp_valid_o && rsp_ready_i) begin
            held_accepts = 0;
            if (ref_q.size() == 0) begin
               problem("response arrived with no request outstanding");
            end else begin
               want = ref_q.pop_front();
               checked++;
               assert ({rsp_resp_o, rsp_rdata_o} == want)
                  else show_mismatch(cur_test, want, {rsp_resp_o, rsp_rdata_o});
            end
         end else if (rsp_valid_o && req_valid_i && req_ready_o) begin
            held_accepts++;
            assert (held_accepts <= 1)
               else problem("second request accepted behind a held response");
         end
         if (req_valid_i && req_ready_o) begin
            ref_q.push_back(expected_rsp(req_write_i, req_addr_i));
            last_sel   = window_sel(req_addr_i);
            last_addr  = req_addr_i;
            last_write = req_write_i;
            last_wdata = req_wdata_i;
            last_wstrb = req_wstrb_i;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // assertions

   dev_route: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      |dev_req_valid_o |-> dev_req_valid_o == last_sel && dev_req_addr_o == last_addr &&
         dev_req_write_o == last_write && dev_req_wdata_o == last_wdata &&
         dev_req_wstrb_o == last_wstrb)
      else show_mismatch(cur_test, {last_sel, last_addr},
                         {$sampled(dev_req_valid_o), $sampled(dev_req_addr_o)});

   rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable({rsp_rdata_o, rsp_resp_o}))
      else problem("response changed while the host held rsp_ready_i low");

   // miss into an empty buffer
   miss_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_valid_i && req_ready_o && window_sel(req_addr_i) == 2'b00 && !rsp_valid_o
      |=> !rsp_valid_o ##1 rsp_valid_o)
      else problem("unmapped request missed its fixed response latency");

   irq_map: assert property (@(posedge clk_i) irq_o == {62'h0, dev_irq_i})
      else show_mismatch("irq", {62'h0, $sampled(dev_irq_i)}, $sampled(irq_o));

   reset_idle: assert property (@(posedge clk_i) !rst_n_i && cycles > 0 |->
      !rsp_valid_o && dev_req_valid_o == '0 && dev_rsp_ready_o == '0 && req_ready_o)
      else problem("control outputs active during reset");

   ////////////////////////////////////////////////////////////////////////////
   // stimulus

   initial begin
      logic [63:0] r;
      lfsr_state   = 32'hd4ee1739;
      clk_i        = 1'b0;
      rst_n_i      = 1'b0;
      req_valid_i  = 1'b0;
      req_write_i  = 1'b0;
      req_addr_i   = '0;
      req_wdata_i  = '0;
      req_wstrb_i  = '0;
      rsp_ready_i  = 1'b0;
      dev_irq_i    = '0;
      acc_delay    = '{2'd0, 2'd0};
      rsp_delay    = '{2'd0, 2'd0};
      rsp_mode     = 0;
      cur_test     = "reset";
      errors       = 0;
      checked      = 0;
      held_accepts = 0;
      cycles       = 0;
      last_sel     = '0;
      last_addr    = '0;
      last_write   = 1'b0;
      last_wdata   = '0;
      last_wstrb   = '0;
      for (int i = 0; i < N_RANDOM; i++) begin
         draw(50, r);
         if (r[49:48] == 2'd3) begin
            gen_addr[i] = r[31:0];  // anywhere, mostly unmapped
         end else begin
            gen_addr[i] = (r[48] ? io_lite_pkg::SPI_BASE : io_lite_pkg::UART_BASE) | r[15:0];
         end
         draw(1, r);
         gen_write[i] = r[0];
         draw(64, r);
         gen_wdata[i] = r;
         draw(8, r);
         gen_wstrb[i] = r[7:0];
      end
      repeat (5) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;

      cur_test = "uart";
      send(1'b1, io_lite_pkg::UART_BASE + 32'h10, 64'h1122_3344_5566_7788, 8'hff);
      send(1'b0, io_lite_pkg::UART_BASE + 32'h10, 64'h0, 8'h00);
      drain();
      cur_test = "spi";
      send(1'b1, io_lite_pkg::SPI_BASE + 32'h28, 64'hcafe_f00d_0000_0001, 8'h0f);
      send(1'b0, io_lite_pkg::SPI_BASE + 32'hfff8, 64'h0, 8'h00);
      drain();
      cur_test = "unmapped";
      send(1'b0, 32'h1000_0000, 64'h0, 8'h00);
      drain();
      send(1'b1, 32'h8002_0000, 64'hdead_beef_0000_0000, 8'hf0);
      drain();

      cur_test = "backpressure";
      @(posedge clk_i);
      rsp_mode = 2;
      send(1'b0, io_lite_pkg::UART_BASE + 32'h100, 64'h0, 8'h00);
      send(1'b0, 32'h0000_4000, 64'h0, 8'h00);  // routed behind the held response
      fork
         send(1'b1, io_lite_pkg::SPI_BASE + 32'h8, 64'h0123_4567_89ab_cdef, 8'hff);
         begin
            repeat (12) @(negedge clk_i);
            @(posedge clk_i);
            rsp_mode = 0;
         end
      join
      drain();

      cur_test = "random";
      @(posedge clk_i);
      rsp_mode = 1;
      for (int i = 0; i < N_RANDOM; i++) begin
         send(gen_write[i], gen_addr[i], gen_wdata[i], gen_wstrb[i]);
      end
      drain();
      repeat (4) @(negedge clk_i);

      if (checked != N_DIRECTED + N_RANDOM) begin
         problem("fewer responses than requests");
      end
      $display("checked %0d responses, %0d errors", checked, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: tb.f
src/io_lite_pkg.sv
src/io_req_decode.sv
src/io_route.sv
src/io_resp_buffer.sv
src/io_lite_xbar.sv
bench/tb_periph_model.sv
bench/tb_io_lite_xbar.sv

// File: Bender.yml
package:
  name: io_lite_xbar

sources:
  - src/io_lite_pkg.sv
  - src/io_req_decode.sv
  - src/io_route.sv
  - src/io_resp_buffer.sv
  - src/io_lite_xbar.sv
  - target: test
    files:
      - bench/tb_periph_model.sv
      - bench/tb_io_lite_xbar.sv
